// ==== mulExec.f ====
common/mulPkg.sv
logic/alu.sv
multiplier/shiftAddMultiplier.sv
logic/wbRegBank.sv
logic/execUnitTop.sv
tests/execUnitTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the execute unit testbench with Verilator, runs it and checks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module execUnitTb -f mulExec.f -o execUnitSim || exit 1
simOut=$(./obj_dir/execUnitSim)
echo "$simOut"
echo "$simOut" | grep -qx "Testbench passed" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

// ==== tests/execUnitTb.sv ====
// Testbench for the execute unit; drives bus commands and checks results against a behavioral model.
module execUnitTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mulPkg::*;

    localparam word_t base = 32'h0000_4000;
    localparam int numPairs = 40;
    localparam int numCorners = 10;
    localparam int numMul = numPairs + numCorners;
    localparam int numOps = numPairs * 8 + 2 * numMul + 16;
    localparam int clkPeriod = 40;

    logic  clk;
    logic  rst;
    logic  cyc;
    logic  stb;
    logic  we;
    word_t adr;
    word_t datW;
    word_t datR;
    logic  ack;
    word_t rng;
    word_t pairA [numMul];
    word_t pairB [numMul];
    int    errorCount;
    int    checkCount;
    int    testErrors;

    execUnitTop #(
        .regBase(base)
    ) uut (
        .clk(clk),
        .rst(rst),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .datW(datW),
        .datR(datR),
        .ack(ack)
    );

    always #(clkPeriod / 2) clk = ~clk;

    initial begin
        #((numOps * 60 + 1000) * clkPeriod);
        $display("timeout: the tests did not finish in the expected time");
        $display("Testbench failed");
        $finish;
    end

    ackOneCycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack) else begin
        $display("[FAIL] %0t ns: ack stayed high for two cycles", $time);
        errorCount++;
    end

    ackAnswersRequest: assert property (
        @(posedge clk) disable iff (rst) ack |-> $past(cyc && stb)
    ) else begin
        $display("[FAIL] %0t ns: ack without a bus request", $time);
        errorCount++;
    end

    ackOnTime: assert property (
        @(posedge clk) disable iff (rst) (cyc && stb && !ack) |=> ack
    ) else begin
        $display("[FAIL] %0t ns: ack missing one cycle after the request", $time);
        errorCount++;
    end

    function automatic word_t xorshift(input word_t s);
        word_t x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t aluModel(input cmd_e c, input word_t a, input word_t b);
        case (c)
            cmdAdd:  return a + b;
            cmdSub:  return a - b;
            cmdAnd:  return a & b;
            cmdOr:   return a | b;
            cmdXor:  return a ^ b;
            cmdNor:  return ~(a | b);
            cmdSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic dword_t mulModel(input word_t a, input word_t b, input logic isSigned);
        longint sa;
        longint sb;
        sa = $signed(a); // sign extends to 64 bits.
        sb = $signed(b);
        if (isSigned) begin
            return dword_t'(sa * sb);
        end
        return {32'b0, a} * {32'b0, b};
    endfunction

    task automatic checkWord(input string what, input word_t got, input word_t exp);
        checkCount++;
        valueMatch: assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s read %h, expected %h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    // one classic cycle that starts 2 ns after a rising edge.
    task automatic busCycle(input logic write, input int off, input word_t wdata,
                            output word_t rdata);
        int waits;
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = write;
        adr  = base + (word_t'(off) << 2);
        datW = wdata;
        waits = 0;
        do begin
            @(posedge clk);
            #2;
            waits++;
        end while (!ack && waits < 8);
        rdata = datR;
        checkCount++;
        ackLatency: assert (ack && waits == 1) else begin
            $display("[FAIL] %0t ns: ack after %0d cycles at offset %0d", $time, waits, off);
            errorCount++;
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic busWrite(input int off, input word_t data);
        word_t unused;
        busCycle(1'b1, off, data, unused);
    endtask

    task automatic busRead(input int off, output word_t data);
        busCycle(1'b0, off, '0, data);
    endtask

    task automatic readExpect(input int off, input word_t exp, input string what);
        word_t got;
        busRead(off, got);
        checkWord(what, got, exp);
    endtask

    task automatic waitIdle();
        word_t st;
        int polls;
        polls = 0;
        do begin
            busRead(regStatus, st);
            polls++;
        end while (st[0] && polls < 40);
        checkCount++;
        idleReached: assert (!st[0]) else begin
            $display("multiply still busy after %0d status reads", polls);
            errorCount++;
        end
    endtask

    task automatic runMultiply(input word_t a, input word_t b, input logic isSigned);
        dword_t exp;
        exp = mulModel(a, b, isSigned);
        busWrite(regOpA, a);
        busWrite(regOpB, b);
        busWrite(regCmd, isSigned ? cmdMult : cmdMultu);
        waitIdle();
        readExpect(regHi, exp[63:32], "product hi");
        readExpect(regLo, exp[31:0], "product lo");
    endtask

    task automatic setPair(input int i, input word_t a, input word_t b);
        pairA[i] = a;
        pairB[i] = b;
    endtask

    task automatic endTest(input string name);
        $display("test %s done, %0d failures", name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    initial begin
        word_t a;
        word_t b;
        word_t exp;
        word_t st;
        clk = 1'b0;
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        datW = '0;
        rng = 32'hcedf;
        errorCount = 0;
        checkCount = 0;
        testErrors = 0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        repeat (2) begin
            @(posedge clk);
            #2;
            checkWord("idle ack", {31'b0, ack}, 32'd0);
        end
        for (int r = 0; r <= 6; r++) begin
            readExpect(r, '0, "register after reset");
        end
        endTest("reset");

        busWrite(regOpA, 32'h1357_9bdf);
        busWrite(regOpB, 32'h2468_ace0);
        busWrite(7, 32'hdead_beef); // unmapped word in the decode range.
        busWrite(64, 32'hcafe_f00d); // outside the decode range.
        readExpect(7, '0, "unmapped offset");
        readExpect(64, '0, "out of range address");
        readExpect(regOpA, 32'h1357_9bdf, "operand A");
        readExpect(regOpB, 32'h2468_ace0, "operand B");
        for (int r = 2; r <= 6; r++) begin
            readExpect(r, '0, "register after unmapped write");
        end
        endTest("bus handshake");

        for (int i = 0; i < numPairs; i++) begin
            rng = xorshift(rng);
            a = rng;
            rng = xorshift(rng);
            b = (i % 8 == 0) ? a : rng; // equal operands force a zero sub.
            busWrite(regOpA, a);
            busWrite(regOpB, b);
            for (int c = 0; c < 8; c++) begin
                exp = aluModel(cmd_e'(4'(c)), a, b);
                busWrite(regCmd, word_t'(c));
                readExpect(regResult, exp, "alu result");
                readExpect(regStatus, {30'b0, exp == '0, 1'b0}, "alu status");
            end
        end
        endTest("alu commands");

        setPair(0, 32'h0000_0000, 32'h1234_5678);
        setPair(1, 32'h0000_0001, 32'h0000_0001);
        setPair(2, 32'hffff_ffff, 32'hffff_ffff);
        setPair(3, 32'h8000_0000, 32'h8000_0000);
        setPair(4, 32'h8000_0000, 32'h0000_0001);
        setPair(5, 32'hffff_ffff, 32'h0000_0001);
        setPair(6, 32'h7fff_ffff, 32'h8000_0000);
        setPair(7, 32'h0000_0005, 32'hffff_fffb);
        setPair(8, 32'hffff_fff9, 32'h0000_0003);
        setPair(9, 32'h8000_0000, 32'hffff_ffff);
        for (int i = numCorners; i < numMul; i++) begin
            rng = xorshift(rng);
            pairA[i] = rng;
            rng = xorshift(rng);
            pairB[i] = rng;
        end
        for (int i = 0; i < numMul; i++) begin
            runMultiply(pairA[i], pairB[i], 1'b0);
        end
        endTest("multu");
        for (int i = 0; i < numMul; i++) begin
            runMultiply(pairA[i], pairB[i], 1'b1);
        end
        endTest("mult");

        rng = xorshift(rng);
        a = rng;
        rng = xorshift(rng);
        b = rng;
        busWrite(regOpA, a);
        busWrite(regOpB, b);
        busWrite(regCmd, cmdMult);
        busRead(regStatus, st);
        checkWord("busy bit after command", {31'b0, st[0]}, 32'd1);
        busWrite(regOpA, ~a); // dropped while busy.
        busWrite(regCmd, cmdMultu);
        waitIdle();
        exp = word_t'(mulModel(a, b, 1'b1) >> 32);
        readExpect(regHi, exp, "hi with writes during busy");
        exp = word_t'(mulModel(a, b, 1'b1));
        readExpect(regLo, exp, "lo with writes during busy");
        readExpect(regOpA, a, "operand A after busy write");
        readExpect(regCmd, word_t'(cmdMult), "command after busy write");
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            a = rng;
            rng = xorshift(rng);
            runMultiply(a, rng, i[0]);
        end
        endTest("busy writes and back to back");

        $display("checks %0d, failures %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== logic/execUnitTop.sv ====
// Top level of the execute unit, wiring the bus register bank, shared ALU and multiplier.
module execUnitTop #(
    parameter mulPkg::word_t regBase = 32'h0000_1000
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          cyc,
    input  logic          stb,
    input  logic          we,
    input  mulPkg::word_t adr,
    input  mulPkg::word_t datW,
    output mulPkg::word_t datR,
    output logic          ack
);
    import mulPkg::*;

    word_t  aluA;
    word_t  aluB;
    aluOp_e aluOp;
    word_t  aluOut;
    logic   aluZero;
    word_t  mulAluA;
    word_t  mulAluB;
    word_t  srcA;
    word_t  srcB;
    word_t  hi;
    word_t  lo;
    logic   mulEnable;
    logic   mulSigned;
    logic   completed;

    wbRegBank #(
        .regBase(regBase)
    ) regBank (
        .clk(clk),
        .rst(rst),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .datW(datW),
        .aluOut(aluOut),
        .aluZero(aluZero),
        .mulAluA(mulAluA),
        .mulAluB(mulAluB),
        .completed(completed),
        .hi(hi),
        .lo(lo),
        .ack(ack),
        .datR(datR),
        .aluA(aluA),
        .aluB(aluB),
        .aluOp(aluOp),
        .srcA(srcA),
        .srcB(srcB),
        .mulEnable(mulEnable),
        .mulSigned(mulSigned)
    );

    alu sharedAlu (
        .a(aluA),
        .b(aluB),
        .op(aluOp),
        .y(aluOut),
        .zero(aluZero)
    );

    shiftAddMultiplier mul (
        .clk(clk),
        .rst(rst),
        .srcA(srcA),
        .srcB(srcB),
        .mulEnable(mulEnable),
        .mulSigned(mulSigned),
        .aluOut(aluOut),
        .aluA(mulAluA),
        .aluB(mulAluB),
        .hi(hi),
        .lo(lo),
        .completed(completed)
    );

endmodule

// ==== logic/wbRegBank.sv ====
// Wishbone classic register bank that decodes commands, owns the ALU inputs and starts multiplies.
module wbRegBank #(
    parameter mulPkg::word_t regBase = 32'h0000_1000
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           cyc,
    input  logic           stb,
    input  logic           we,
    input  mulPkg::word_t  adr,
    input  mulPkg::word_t  datW,
    input  mulPkg::word_t  aluOut,
    input  logic           aluZero,
    input  mulPkg::word_t  mulAluA,
    input  mulPkg::word_t  mulAluB,
    input  logic           completed,
    input  mulPkg::word_t  hi,
    input  mulPkg::word_t  lo,
    output logic           ack,
    output mulPkg::word_t  datR,
    output mulPkg::word_t  aluA,
    output mulPkg::word_t  aluB,
    output mulPkg::aluOp_e aluOp,
    output mulPkg::word_t  srcA,
    output mulPkg::word_t  srcB,
    output logic           mulEnable,
    output logic           mulSigned
);
    import mulPkg::*;

    typedef enum logic {
        ctlIdle,
        ctlMul
    } ctlState_e;

    ctlState_e  state;
    word_t      opA;
    word_t      opB;
    word_t      result;
    word_t      offset;
    word_t      readData;
    logic [3:0] cmdReg;
    logic       zeroFlag;
    logic       busy;
    logic       hit;
    logic       req;
    logic       wrReq;
    logic       rdReq;
    regAddr_e   regSel;
    cmd_e       cmdIn;

    // byte address, eight words decoded from regBase.
    assign offset = adr - regBase;
    assign hit    = (offset[31:5] == '0);
    assign regSel = regAddr_e'(offset[4:2]);
    assign cmdIn  = cmd_e'(datW[3:0]);

    assign req   = cyc && stb && !ack; // first cycle of a request.
    assign wrReq = req && we && hit;
    assign rdReq = req && !we;

    assign busy      = (state == ctlMul);
    assign mulEnable = busy;
    assign srcA      = opA;
    assign srcB      = opB;

    // the multiplier owns the adder while busy.
    assign aluA  = busy ? mulAluA : opA;
    assign aluB  = busy ? mulAluB : opB;
    assign aluOp = busy ? opAdd : aluOp_e'(datW[2:0]);

    always_comb begin
        readData = '0;
        if (hit) begin
            case (regSel)
                regOpA:    readData = opA;
                regOpB:    readData = opB;
                regCmd:    readData = {28'b0, cmdReg};
                regResult: readData = result;
                regHi:     readData = hi;
                regLo:     readData = lo;
                regStatus: readData = {30'b0, zeroFlag, busy};
                default:   readData = '0; // unmapped word.
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack  <= 1'b0;
            datR <= '0;
        end else begin
            ack  <= req;
            datR <= rdReq ? readData : '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            opA <= '0;
            opB <= '0;
        end else if (wrReq && !busy) begin
            if (regSel == regOpA) begin
                opA <= datW;
            end
            if (regSel == regOpB) begin
                opB <= datW;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ctlIdle;
            mulSigned <= 1'b0;
            cmdReg    <= '0;
            result    <= '0;
            zeroFlag  <= 1'b0;
        end else if (wrReq && regSel == regCmd && !busy) begin
            cmdReg <= datW[3:0];
            if (!datW[3]) begin
                result   <= aluOut; // ALU settles within the ack cycle.
                zeroFlag <= aluZero;
            end else if (cmdIn == cmdMult || cmdIn == cmdMultu) begin
                state     <= ctlMul;
                mulSigned <= (cmdIn == cmdMult);
            end
        end else if (busy && completed) begin
            state <= ctlIdle; // drop enable once HI and LO are final.
        end
    end

    ackSingleCycle: assert property (
        @(posedge clk) disable iff (rst)
        ack |=> !ack
    ) else $error("ack held high for two cycles");

    signedStable: assert property (
        @(posedge clk) disable iff (rst)
        mulEnable && $past(mulEnable) |-> $stable(mulSigned)
    ) else $error("mulSigned changed during a multiply");

endmodule

// ==== multiplier/shiftAddMultiplier.sv ====
// Shift-and-add multiplier that borrows the shared ALU adder and writes the product to HI and LO.
module shiftAddMultiplier (
    input  logic          clk,
    input  logic          rst,
    input  mulPkg::word_t srcA,
    input  mulPkg::word_t srcB,
    input  logic          mulEnable,
    input  logic          mulSigned,
    input  mulPkg::word_t aluOut,
    output mulPkg::word_t aluA,
    output mulPkg::word_t aluB,
    output mulPkg::word_t hi,
    output mulPkg::word_t lo,
    output logic          completed
);
    import mulPkg::*;

    // counter 0 seeds, 1..mulSteps add and shift, then the output step.
    localparam logic [5:0] outStep = 6'(mulSteps + 1);

    logic [5:0] counter;
    dword_t     product;
    dword_t     productOut;
    word_t      magA;
    word_t      magB;
    logic       negRes;
    logic       carry;

    // operands stay put while enabled, so magnitudes are taken straight from them.
    assign magA   = (mulSigned && srcA[31]) ? (~srcA + 32'd1) : srcA;
    assign magB   = (mulSigned && srcB[31]) ? (~srcB + 32'd1) : srcB;
    assign negRes = mulSigned && (srcA[31] ^ srcB[31]);

    // upper half plus multiplicand goes through the external adder.
    assign aluA = product[63:32];
    assign aluB = magB;

    // 32-bit sum wrapped if it is below an addend.
    assign carry = aluOut < magB;

    // sign fixup lands in the same cycle as the output step.
    assign productOut = negRes ? (~product + 64'd1) : product;

    always_ff @(posedge clk) begin
        if (mulEnable) begin
            if (counter == '0) begin
                product <= {32'b0, magA}; // multiplier in the low half.
            end else if (counter <= mulSteps) begin
                if (product[0]) begin
                    product <= {carry, aluOut, product[31:1]};
                end else begin
                    product <= {1'b0, product[63:1]};
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter   <= '0;
            completed <= 1'b0;
            hi        <= '0;
            lo        <= '0;
        end else if (!mulEnable) begin
            counter   <= '0; // ready for the next command.
            completed <= 1'b0;
        end else if (counter != outStep) begin
            counter <= counter + 6'd1;
        end else begin
            completed <= 1'b1; // held until enable drops.
            hi        <= productOut[63:32];
            lo        <= productOut[31:0];
        end
    end

    counterRange: assert property (
        @(posedge clk) disable iff (rst)
        counter <= outStep
    ) else $error("multiplier step counter ran past the output step");

    // completed must answer a held enable, never appear on its own.
    completedFollowsEnable: assert property (
        @(posedge clk) disable iff (rst)
        completed |-> $past(mulEnable)
    ) else $error("completed raised without enable on the previous cycle");

endmodule

// ==== logic/alu.sv ====
// Combinational 32-bit ALU, shared by bus commands and the multiplier's add steps.
module alu (
    input  mulPkg::word_t  a,
    input  mulPkg::word_t  b,
    input  mulPkg::aluOp_e op,
    output mulPkg::word_t  y,
    output logic           zero
);
    import mulPkg::*;

    logic sltSigned;
    logic sltUnsigned;

    assign sltSigned   = $signed(a) < $signed(b);
    assign sltUnsigned = a < b;

    always_comb begin
        case (op)
            opAdd: begin
                y = a + b;
            end
            opSub: begin
                y = a - b;
            end
            opAnd: begin
                y = a & b;
            end
            opOr: begin
                y = a | b;
            end
            opXor: begin
                y = a ^ b;
            end
            opNor: begin
                y = ~(a | b);
            end
            opSlt: begin
                y = {31'b0, sltSigned}; // two's complement compare.
            end
            opSltu: begin
                y = {31'b0, sltUnsigned};
            end
            default: begin
                y = '0;
            end
        endcase
    end

    assign zero = (y == '0);

endmodule

// ==== common/mulPkg.sv ====
// Shared word types, ALU functions, command codes and register map of the execute unit.
package mulPkg;

    typedef logic [31:0] word_t;  // operand, ALU value or bus word.
    typedef logic [63:0] dword_t; // raw multiplier product.

    // number of add-and-shift iterations for a 32-bit multiply.
    localparam int mulSteps = 32;

    typedef enum logic [2:0] {
        opAdd  = 3'd0,
        opSub  = 3'd1,
        opAnd  = 3'd2,
        opOr   = 3'd3,
        opXor  = 3'd4,
        opNor  = 3'd5,
        opSlt  = 3'd6,
        opSltu = 3'd7
    } aluOp_e;

    // low three bits of an ALU command equal its aluOp_e code.
    typedef enum logic [3:0] {
        cmdAdd   = 4'd0,
        cmdSub   = 4'd1,
        cmdAnd   = 4'd2,
        cmdOr    = 4'd3,
        cmdXor   = 4'd4,
        cmdNor   = 4'd5,
        cmdSlt   = 4'd6,
        cmdSltu  = 4'd7,
        cmdMult  = 4'd8,
        cmdMultu = 4'd9
    } cmd_e;

    // word offsets from the bus base address.
    typedef enum logic [2:0] {
        regOpA    = 3'd0,
        regOpB    = 3'd1,
        regCmd    = 3'd2,
        regResult = 3'd3,
        regHi     = 3'd4,
        regLo     = 3'd5,
        regStatus = 3'd6
    } regAddr_e;

endpackage
